// File: Makefile
TOP := fetch_top_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -sv --top-module $(TOP) -f build.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
verilog/fetch_cfg_pkg.sv
verilog/isa_pkg.sv
verilog/fetch_ifs.sv
verilog/fetch_ctrl.sv
verilog/pc_unit.sv
verilog/imem.sv
verilog/fetch_out_reg.sv
verilog/fetch_top.sv
test/fetch_top_tb.sv

// File: program.hex
// One 32-bit instruction word per line, word address 0 to 15.
00000013
00100093
00200113
002081b3
40208233
0041a2b3
00a00313
00131393
0063c433
00846493
00c4f513
00550863
fff50513
00b52023
00052583
fc5ff06f

// File: test/fetch_top_tb.sv
`timescale 1ns/1ps

module fetch_top_tb;

  import fetch_cfg_pkg::*;
  import isa_pkg::*;

  typedef enum logic [1:0] {
    REDIR_NONE,
    REDIR_BRANCH,
    REDIR_JUMP
  } redir_kind_t;

  // Instructions to accept, then an optional redirect.
  typedef struct {
    int          count;
    logic        rand_stall;
    logic        rand_busy;
    redir_kind_t redir;
    addr_t       target;
  } step_t;

  typedef logic [$clog2(MEM_WORDS)-1:0] word_idx_t;

  logic         clk_i;
  logic         rst_i;
  logic         mem_busy_i;
  logic         dec_stall_i;
  logic         branch_taken_i;
  logic         jump_i;
  addr_t        branch_target_i;
  addr_t        jump_addr_i;
  logic         dec_valid_o;
  addr_t        dec_pc_o;
  instruction_t dec_instr_o;

  instruction_t rom_ref [MEM_WORDS];
  step_t        steps [$];
  addr_t        exp_pc;
  int           busy_left;
  int           errors;
  int           cycle_cnt;
  int           timeout_limit;

  fetch_top i_fetch_top (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .mem_busy_i      (mem_busy_i),
    .dec_stall_i     (dec_stall_i),
    .branch_taken_i  (branch_taken_i),
    .jump_i          (jump_i),
    .branch_target_i (branch_target_i),
    .jump_addr_i     (jump_addr_i),
    .dec_valid_o     (dec_valid_o),
    .dec_pc_o        (dec_pc_o),
    .dec_instr_o     (dec_instr_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("Timeout after %0d cycles, decode did not receive all instructions", cycle_cnt);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check_pc(input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("** Error dec_pc_o: got %h, expected %h at %0t", got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_instr(input instruction_t got, input instruction_t exp);
    if (got !== exp) begin
      $display("** Error dec_instr_o: got %h, expected %h at %0t", got, exp, $time);
      errors++;
    end
  endtask

  task automatic apply_busy;
    mem_busy_i = (busy_left > 0);
    if (busy_left > 0) begin
      busy_left--;
    end
  endtask

  // Drive point of the next cycle.
  task automatic next_cycle;
    @(posedge clk_i);
    #5;
    apply_busy();
  endtask

  task automatic add_step(input int count, input logic rand_stall, input logic rand_busy,
                          input redir_kind_t redir, input addr_t target);
    step_t row;
    row.count      = count;
    row.rand_stall = rand_stall;
    row.rand_busy  = rand_busy;
    row.redir      = redir;
    row.target     = target;
    steps.push_back(row);
  endtask

  function automatic string redir_name(input redir_kind_t kind);
    case (kind)
      REDIR_BRANCH: return "branch";
      REDIR_JUMP:   return "jump";
      default:      return "none";
    endcase
  endfunction

  task automatic accept_one(input logic rand_stall, input logic rand_busy);
    int stall_left;
    stall_left = rand_stall ? int'($urandom % 4) : 0;
    // Odd stall lengths start before the response lands.
    dec_stall_i = (stall_left % 2 == 1);
    while (dec_valid_o !== 1'b1) begin
      next_cycle();
    end
    if (rand_busy) begin
      busy_left = int'($urandom % 4);
      apply_busy();
    end
    check_pc(dec_pc_o, exp_pc);
    check_instr(dec_instr_o, rom_ref[word_idx_t'(exp_pc >> 2)]);
    // Packet must not move while decode holds it.
    while (stall_left > 0) begin
      dec_stall_i = 1'b1;
      next_cycle();
      stall_left--;
      if (dec_valid_o !== 1'b1) begin
        $display("Valid dropped while decode was stalled at %0t", $time);
        errors++;
      end
      check_pc(dec_pc_o, exp_pc);
      check_instr(dec_instr_o, rom_ref[word_idx_t'(exp_pc >> 2)]);
    end
    dec_stall_i = 1'b0;
    next_cycle();
    if (exp_pc >= addr_t'(MEM_BYTES - 4)) begin
      exp_pc = '0;
    end else begin
      exp_pc = exp_pc + addr_t'(4);
    end
  endtask

  // The unused target input gets a decoy address.
  task automatic pulse_redirect(input redir_kind_t kind, input addr_t target,
                                input logic with_busy);
    addr_t decoy;
    decoy           = (target + addr_t'(8)) % addr_t'(MEM_BYTES);
    branch_taken_i  = (kind == REDIR_BRANCH);
    jump_i          = (kind == REDIR_JUMP);
    branch_target_i = (kind == REDIR_BRANCH) ? target : decoy;
    jump_addr_i     = (kind == REDIR_JUMP) ? target : decoy;
    if (with_busy) begin
      busy_left = 1 + int'($urandom % 3);
      apply_busy();
    end
    next_cycle();
    branch_taken_i = 1'b0;
    jump_i         = 1'b0;
    exp_pc         = target;
  endtask

  initial begin
    int total;
    int step_errors;
    int steps_passed;
    int steps_failed;
    clk_i           = 1'b0;
    rst_i           = 1'b0;
    mem_busy_i      = 1'b0;
    dec_stall_i     = 1'b0;
    branch_taken_i  = 1'b0;
    jump_i          = 1'b0;
    branch_target_i = '0;
    jump_addr_i     = '0;
    cycle_cnt       = 0;
    busy_left       = 0;
    errors          = 0;
    exp_pc          = '0;
    total           = 0;
    steps_passed    = 0;
    steps_failed    = 0;
    void'($urandom(32'hc69a));
    $readmemh(PROGRAM_FILE, rom_ref);
    for (int i = 0; i < MEM_WORDS; i++) begin
      if ($isunknown(rom_ref[word_idx_t'(i)])) begin
        $display("Word %0d of %s is missing or unreadable", i, PROGRAM_FILE);
        errors++;
      end
    end

    // Sequential with two wraps, stalls, busy, then redirects.
    add_step(20, 1'b0, 1'b0, REDIR_NONE,   32'h00);
    add_step(6,  1'b1, 1'b0, REDIR_NONE,   32'h00);
    add_step(6,  1'b0, 1'b1, REDIR_NONE,   32'h00);
    add_step(3,  1'b0, 1'b0, REDIR_BRANCH, 32'h30);
    add_step(5,  1'b1, 1'b1, REDIR_JUMP,   32'h08);
    add_step(4,  1'b0, 1'b1, REDIR_JUMP,   32'h20);
    add_step(4,  1'b1, 1'b1, REDIR_BRANCH, 32'h3c);
    add_step(6,  1'b1, 1'b1, REDIR_NONE,   32'h00);
    for (int s = 0; s < steps.size(); s++) begin
      total += steps[s].count;
    end
    timeout_limit = total * (IMEM_LATENCY + 2 + 6) + 100;

    repeat (16) @(posedge clk_i);
    #5;
    rst_i = 1'b1;

    for (int s = 0; s < steps.size(); s++) begin
      step_errors = errors;
      for (int n = 0; n < steps[s].count; n++) begin
        accept_one(steps[s].rand_stall, steps[s].rand_busy);
      end
      if (steps[s].redir != REDIR_NONE) begin
        pulse_redirect(steps[s].redir, steps[s].target, steps[s].rand_busy);
      end
      if (errors == step_errors) begin
        steps_passed++;
      end else begin
        steps_failed++;
      end
      $display("Step %0d: %0d instructions, stall %0b, busy %0b, redirect %s: %s",
               s, steps[s].count, steps[s].rand_stall, steps[s].rand_busy,
               redir_name(steps[s].redir), (errors == step_errors) ? "ok" : "errors");
    end

    $display("Steps passed: %0d, steps failed: %0d, errors: %0d",
             steps_passed, steps_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule : fetch_top_tb

// File: verilog/fetch_cfg_pkg.sv
package fetch_cfg_pkg;

  // Byte address width.
  localparam int ADDR_WIDTH = 32;

  // Instruction memory size in words.
  localparam int MEM_WORDS = 16;

  // Fetch addresses wrap modulo this.
  localparam int MEM_BYTES = MEM_WORDS * 4;

  // Cycles from accepted request to response.
  localparam int IMEM_LATENCY = 2;

  localparam string PROGRAM_FILE = "program.hex";

  typedef logic [ADDR_WIDTH-1:0] addr_t;

endpackage : fetch_cfg_pkg

// File: verilog/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                mem_busy_i,
  input  logic                dec_stall_i,
  input  logic                branch_taken_i,
  input  logic                jump_i,
  imem_if.ctrl                mem,
  pc_ctrl_if.ctrl             pc,
  output logic                out_load_o,
  output logic                out_clear_o,
  output isa_pkg::fetch_pkt_t out_pkt_o
);

  import fetch_cfg_pkg::*;
  import isa_pkg::*;

  typedef enum logic [2:0] {
    IDLE  = 3'b000,
    REQ   = 3'b001,
    WAIT  = 3'b010,
    FLUSH = 3'b011,
    STALL = 3'b100
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   issue;
  logic   req_valid_q;
  addr_t  req_addr_q;
  logic   redirect_d;
  logic   redirect_q;
  logic   held_q;
  logic   redir_req;
  logic   out_blocked;

  assign redir_req = branch_taken_i | jump_i;

  // Decode still holds an unaccepted packet.
  assign out_blocked = held_q & dec_stall_i;

  always_comb begin
    state_d    = state_q;
    issue      = 1'b0;
    redirect_d = 1'b0;
    out_load_o = 1'b0;
    pc.capture = 1'b0;
    case (state_q)
      IDLE: begin
        state_d = REQ;
      end
      REQ: begin
        // Nothing in flight, redirect goes out next cycle.
        if (redir_req) begin
          pc.capture = 1'b1;
          redirect_d = 1'b1;
        end else if (!redirect_q && !mem_busy_i && !out_blocked) begin
          issue   = 1'b1;
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (redir_req) begin
          pc.capture = 1'b1;
          if (mem.rsp_valid) begin
            // Response arrives with the redirect, drop it now.
            redirect_d = 1'b1;
            state_d    = REQ;
          end else begin
            state_d = FLUSH;
          end
        end else if (mem.rsp_valid) begin
          out_load_o = 1'b1;
          state_d    = dec_stall_i ? STALL : REQ;
        end
      end
      FLUSH: begin
        if (redir_req) begin
          pc.capture = 1'b1;
        end
        if (mem.rsp_valid) begin
          redirect_d = 1'b1;
          state_d    = REQ;
        end
      end
      STALL: begin
        if (!dec_stall_i) begin
          state_d = REQ;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Clear on acceptance unless a new packet lands.
  assign out_clear_o = held_q & ~dec_stall_i & ~out_load_o;
  assign out_pkt_o   = '{pc: req_addr_q, instr: mem.rsp_instr};

  assign pc.advance  = out_load_o;
  assign pc.sel_jump = jump_i & ~branch_taken_i;
  assign pc.redirect = redirect_q;

  assign mem.req_valid = req_valid_q;
  assign mem.req_addr  = req_addr_q;
  assign mem.req_size  = WORD;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q     <= IDLE;
      req_valid_q <= 1'b0;
      redirect_q  <= 1'b0;
      held_q      <= 1'b0;
    end else begin
      state_q     <= state_d;
      req_valid_q <= issue;
      redirect_q  <= redirect_d;
      if (out_load_o) begin
        held_q <= 1'b1;
      end else if (out_clear_o) begin
        held_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      req_addr_q <= pc.pc;
    end
  end

endmodule : fetch_ctrl

// File: verilog/fetch_ifs.sv
`timescale 1ns/1ps

// Instruction memory request and response.
interface imem_if;

  import fetch_cfg_pkg::*;
  import isa_pkg::*;

  logic         req_valid;
  addr_t        req_addr;
  access_size_t req_size;
  logic         rsp_valid;
  instruction_t rsp_instr;

  modport ctrl (
    output req_valid,
    output req_addr,
    output req_size,
    input  rsp_valid,
    input  rsp_instr
  );

  modport mem (
    input  req_valid,
    input  req_addr,
    input  req_size,
    output rsp_valid,
    output rsp_instr
  );

endinterface : imem_if

// PC control strobes and current fetch address.
interface pc_ctrl_if;

  import fetch_cfg_pkg::*;

  logic  advance;
  logic  capture;
  logic  sel_jump;
  logic  redirect;
  addr_t pc;

  modport ctrl (
    output advance,
    output capture,
    output sel_jump,
    output redirect,
    input  pc
  );

  modport unit (
    input  advance,
    input  capture,
    input  sel_jump,
    input  redirect,
    output pc
  );

endinterface : pc_ctrl_if

// File: verilog/fetch_out_reg.sv
`timescale 1ns/1ps

module fetch_out_reg (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                load_i,
  input  logic                clear_i,
  input  isa_pkg::fetch_pkt_t pkt_i,
  output logic                valid_o,
  output isa_pkg::fetch_pkt_t pkt_o
);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_o <= 1'b0;
    end else if (load_i) begin
      valid_o <= 1'b1;
    end else if (clear_i) begin
      valid_o <= 1'b0;
    end
  end

  // Packet holds until the next load, stable through stalls.
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      pkt_o <= pkt_i;
    end
  end

endmodule : fetch_out_reg

// File: verilog/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  mem_busy_i,
  input  logic                  dec_stall_i,
  input  logic                  branch_taken_i,
  input  logic                  jump_i,
  input  fetch_cfg_pkg::addr_t  branch_target_i,
  input  fetch_cfg_pkg::addr_t  jump_addr_i,
  output logic                  dec_valid_o,
  output fetch_cfg_pkg::addr_t  dec_pc_o,
  output isa_pkg::instruction_t dec_instr_o
);

  import isa_pkg::*;

  imem_if    mem_bus ();
  pc_ctrl_if pc_ctrl ();

  logic       out_load;
  logic       out_clear;
  fetch_pkt_t out_pkt;
  fetch_pkt_t dec_pkt;

  fetch_ctrl i_fetch_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .mem_busy_i     (mem_busy_i),
    .dec_stall_i    (dec_stall_i),
    .branch_taken_i (branch_taken_i),
    .jump_i         (jump_i),
    .mem            (mem_bus.ctrl),
    .pc             (pc_ctrl.ctrl),
    .out_load_o     (out_load),
    .out_clear_o    (out_clear),
    .out_pkt_o      (out_pkt)
  );

  pc_unit i_pc_unit (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .branch_target_i (branch_target_i),
    .jump_addr_i     (jump_addr_i),
    .ctl             (pc_ctrl.unit)
  );

  imem i_imem (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (mem_bus.mem)
  );

  fetch_out_reg i_fetch_out_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .load_i  (out_load),
    .clear_i (out_clear),
    .pkt_i   (out_pkt),
    .valid_o (dec_valid_o),
    .pkt_o   (dec_pkt)
  );

  assign dec_pc_o    = dec_pkt.pc;
  assign dec_instr_o = dec_pkt.instr;

endmodule : fetch_top

// File: verilog/imem.sv
`timescale 1ns/1ps

module imem (
  input  logic clk_i,
  input  logic rst_i,
  imem_if.mem  bus
);

  import fetch_cfg_pkg::*;
  import isa_pkg::*;

  instruction_t                 rom    [MEM_WORDS];
  instruction_t                 data_q [IMEM_LATENCY];
  logic [IMEM_LATENCY-1:0]      vld_q;
  logic [$clog2(MEM_WORDS)-1:0] rd_idx;
  logic                         accept;

  initial begin
    $readmemh(PROGRAM_FILE, rom);
  end

  // Word index from the byte address.
  assign rd_idx = bus.req_addr[$clog2(MEM_WORDS)+1:2];

  // Only word reads are served.
  assign accept = bus.req_valid & (bus.req_size == WORD);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= accept;
      for (int i = 1; i < IMEM_LATENCY; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    data_q[0] <= rom[rd_idx];
    for (int i = 1; i < IMEM_LATENCY; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign bus.rsp_valid = vld_q[IMEM_LATENCY-1];
  assign bus.rsp_instr = data_q[IMEM_LATENCY-1];

endmodule : imem

// File: verilog/isa_pkg.sv
package isa_pkg;

  // Raw 32-bit instruction word.
  typedef logic [31:0] instruction_t;

  // Memory access size. Fetch only ever uses WORD.
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } access_size_t;

  // One fetched instruction with its address.
  typedef struct packed {
    fetch_cfg_pkg::addr_t pc;
    instruction_t         instr;
  } fetch_pkt_t;

endpackage : isa_pkg

// File: verilog/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  fetch_cfg_pkg::addr_t branch_target_i,
  input  fetch_cfg_pkg::addr_t jump_addr_i,
  pc_ctrl_if.unit              ctl
);

  import fetch_cfg_pkg::*;

  addr_t pc_q;
  addr_t pc_next;
  addr_t target_q;

  // Next word, wrapping at the end of memory.
  assign pc_next = (pc_q + addr_t'(4)) % addr_t'(MEM_BYTES);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q <= '0;
    end else if (ctl.redirect) begin
      pc_q <= target_q;
    end else if (ctl.advance) begin
      pc_q <= pc_next;
    end
  end

  // Pending redirect target.
  always_ff @(posedge clk_i) begin
    if (ctl.capture) begin
      target_q <= ctl.sel_jump ? jump_addr_i : branch_target_i;
    end
  end

  assign ctl.pc = pc_q;

endmodule : pc_unit
